/* flist.f */
vec_cfg_pkg.sv
vec_types_pkg.sv
vec_sequencer.sv
vec_reg_file.sv
vec_lane_alu.sv
vec_unit.sv
vec_unit_checker.sv
vec_unit_tb.sv

/* vec_unit_tb.sv */
// testbench top: clock, reset, random vector instructions and host read sweeps
`timescale 1ns/1ps

module vec_unit_tb;

  logic                   CLK;
  logic                   nRST;
  logic                   start;
  vec_types_pkg::vop_t    op;
  vec_types_pkg::regsel_t vd, vs1, vs2, rd_reg;
  vec_types_pkg::sew_t    sew, rd_sew;
  vec_types_pkg::vlen_t   vl;
  vec_types_pkg::offset_t rd_offset;
  vec_types_pkg::elem_t   scalar, rd_data;
  logic                   busy, done;
  int                     seed_ret;

  vec_unit DUT (
    .CLK, .nRST, .start, .op, .vd, .vs1, .vs2, .sew, .vl, .scalar,
    .rd_reg, .rd_offset, .rd_sew, .rd_data, .busy, .done
  );

  vec_unit_checker chk (
    .CLK, .nRST, .start, .busy, .done, .op, .vd, .vs1, .vs2, .rd_reg,
    .sew, .rd_sew, .vl, .rd_offset, .scalar, .rd_data
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // group limit, 8 registers worth of elements
  function automatic vec_types_pkg::vlen_t max_vl(input vec_types_pkg::sew_t w);
    return vec_types_pkg::vlen_t'((vec_cfg_pkg::MAX_GROUP * vec_cfg_pkg::VLENB) >> w);
  endfunction

  function automatic vec_types_pkg::sew_t rand_sew();
    return vec_types_pkg::sew_t'($urandom_range(2, 0));
  endfunction

  // one instruction, optionally a second start while busy, then wait for done
  task automatic run_instr(input vec_types_pkg::vop_t o, input vec_types_pkg::regsel_t d,
                           input vec_types_pkg::regsel_t s1, input vec_types_pkg::regsel_t s2,
                           input vec_types_pkg::sew_t w, input vec_types_pkg::vlen_t n,
                           input bit intrude);
    int cnt;
    @(posedge CLK);
    start  <= 1'b1;
    op     <= o;
    vd     <= d;
    vs1    <= s1;
    vs2    <= s2;
    sew    <= w;
    vl     <= n;
    scalar <= $urandom;
    @(posedge CLK);
    start <= intrude;
    vd    <= d + 5'd3;  // would overlap the group if taken
    @(posedge CLK);
    start <= 1'b0;
    cnt = 0;
    @(negedge CLK);
    while (!done && cnt < 200) begin
      @(negedge CLK);
      cnt++;
    end
    if (!done) begin
      $display("timeout: no done within 200 cycles in test %s", chk.test_name);
      $display("SIMULATION FAILED");
      $finish;
    end
  endtask

  task automatic sweep_group(input vec_types_pkg::regsel_t base, input vec_types_pkg::sew_t w);
    for (int i = 0; i < int'(max_vl(w)); i++) begin
      @(posedge CLK);
      rd_reg    <= base;
      rd_offset <= vec_types_pkg::offset_t'(i);
      rd_sew    <= w;
    end
    @(posedge CLK);
  endtask

  // two splats at random widths leave uneven source contents
  task automatic setup_operands(input vec_types_pkg::regsel_t s1, input vec_types_pkg::regsel_t s2);
    vec_types_pkg::sew_t w;
    for (int k = 0; k < 4; k++) begin
      w = rand_sew();
      run_instr(vec_types_pkg::VMV_X, (k < 2) ? s1 : s2, 5'd0, 5'd0, w,
                (k % 2 == 0) ? max_vl(w) : vec_types_pkg::vlen_t'($urandom_range(max_vl(w), 0)),
                1'b0);
    end
  endtask

  // groups start at r + 8k, so any two are equal or disjoint
  task automatic pick_regs(output vec_types_pkg::regsel_t d, output vec_types_pkg::regsel_t s1,
                           output vec_types_pkg::regsel_t s2);
    int r;
    r  = $urandom_range(31, 0);
    d  = vec_types_pkg::regsel_t'(r + 8 * $urandom_range(3, 0));
    s1 = vec_types_pkg::regsel_t'(r + 8 * $urandom_range(3, 0));
    s2 = vec_types_pkg::regsel_t'(r + 8 * $urandom_range(3, 0));
  endtask

  initial begin
    vec_types_pkg::regsel_t d, s1, s2;
    vec_types_pkg::sew_t    w;
    vec_types_pkg::vlen_t   n;
    seed_ret = $urandom(12);
    nRST = 1'b0;
    start = 1'b0;
    op = vec_types_pkg::VADD;
    vd = '0;
    vs1 = '0;
    vs2 = '0;
    sew = vec_types_pkg::SEW8;
    vl = '0;
    scalar = '0;
    rd_reg = '0;
    rd_offset = '0;
    rd_sew = vec_types_pkg::SEW8;
    repeat (16) @(posedge CLK);
    nRST <= 1'b1;

    chk.begin_test("reset");
    for (int r = 0; r < vec_cfg_pkg::NUM_REGS; r += 8) begin
      sweep_group(vec_types_pkg::regsel_t'(r), vec_types_pkg::SEW32);
    end
    chk.end_test();

    chk.begin_test("move");
    for (int k = 0; k < 12; k++) begin
      pick_regs(d, s1, s2);
      w = vec_types_pkg::sew_t'(k % 3);
      n = (k < 6) ? max_vl(w) - 1 : vec_types_pkg::vlen_t'($urandom_range(max_vl(w), 0));
      setup_operands(s1, d);  // old destination values must survive past vl
      run_instr((k % 2) ? vec_types_pkg::VMV_V : vec_types_pkg::VMV_X, d, s1, s2, w, n, 1'b0);
      sweep_group(d, w);
    end
    chk.end_test();

    chk.begin_test("alu");
    for (int o = 0; o < 5; o++) begin
      for (int k = 0; k < 3; k++) begin
        pick_regs(d, s1, s2);
        w = vec_types_pkg::sew_t'(k);
        setup_operands(s1, s2);
        n = vec_types_pkg::vlen_t'($urandom_range(max_vl(w), 0));
        run_instr(vec_types_pkg::vop_t'(o), d, s1, s2, w, n, 1'b0);
        sweep_group(d, w);
      end
    end
    chk.end_test();

    chk.begin_test("latency");
    for (int k = 0; k < 6; k++) begin
      pick_regs(d, s1, s2);
      w = rand_sew();
      n = (k < 3) ? vec_types_pkg::vlen_t'(k) : max_vl(w) - vec_types_pkg::vlen_t'(k - 3);
      run_instr(vec_types_pkg::vop_t'($urandom_range(6, 0)), d, s1, s2, w, n, 1'b0);
    end
    chk.end_test();

    chk.begin_test("busy_start");
    for (int k = 0; k < 6; k++) begin
      d = vec_types_pkg::regsel_t'(27 + k);  // groups wrap past v31
      w = rand_sew();
      setup_operands(d + 5'd8, d + 5'd16);
      run_instr(vec_types_pkg::vop_t'($urandom_range(6, 0)), d, d + 5'd8, d + 5'd16, w,
                max_vl(w), 1'b1);
      sweep_group(d, w);
    end
    chk.end_test();

    chk.begin_test("cross_width");
    for (int k = 0; k < 6; k++) begin
      pick_regs(d, s1, s2);
      w = rand_sew();
      setup_operands(s1, s2);
      run_instr(vec_types_pkg::vop_t'($urandom_range(6, 0)), d, s1, s2, w,
                vec_types_pkg::vlen_t'($urandom_range(max_vl(w), 0)), 1'b0);
      for (int rw = 0; rw < 3; rw++) begin
        sweep_group(d, vec_types_pkg::sew_t'(rw));
      end
    end
    chk.end_test();

    $display("%0d tests run, %0d errors", chk.tests, chk.errors);
    if (chk.errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

/* vec_unit_checker.sv */
// testbench checker: byte model of the register file, host read and done latency checks
`timescale 1ns/1ps

module vec_unit_checker (
  input logic                   CLK, nRST, start, busy, done,
  input vec_types_pkg::vop_t    op,
  input vec_types_pkg::regsel_t vd, vs1, vs2, rd_reg,
  input vec_types_pkg::sew_t    sew, rd_sew,
  input vec_types_pkg::vlen_t   vl,
  input vec_types_pkg::offset_t rd_offset,
  input vec_types_pkg::elem_t   scalar, rd_data
);

  logic [7:0] model [vec_cfg_pkg::NUM_REGS][vec_cfg_pkg::VLENB];
  string test_name = "reset";
  int    errors = 0;
  int    test_errors = 0;
  int    tests = 0;
  int    cycle;
  int    start_cycle;
  int    due;      // expected start-to-done latency
  int    lat;
  bit    pending;

  task automatic note_mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    test_errors++;
    $display("mismatch in %s: %s expected %h actual %h", test_name, what, exp, act);
  endtask

  task automatic note_error(input string msg);
    errors++;
    test_errors++;
    $display("error in %s: %s", test_name, msg);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests++;
    $display("test %-10s %s (%0d errors)", test_name, (test_errors == 0) ? "ok" : "failed",
             test_errors);
  endtask

  function automatic int elem_bytes(input vec_types_pkg::sew_t w);
    return 1 << w;  // 1, 2 or 4 bytes
  endfunction

  // little-endian bytes, group walks on into the next registers
  function automatic logic [31:0] get_elem(input int base, input int e, input vec_types_pkg::sew_t w);
    logic [31:0] v;
    int a;
    v = '0;
    for (int i = 0; i < elem_bytes(w); i++) begin
      a = e * elem_bytes(w) + i;  // byte position in the group
      v[8*i +: 8] = model[(base + a / vec_cfg_pkg::VLENB) % vec_cfg_pkg::NUM_REGS]
                         [a % vec_cfg_pkg::VLENB];
    end
    return v;
  endfunction

  task automatic put_elem(input int base, input int e, input vec_types_pkg::sew_t w,
                          input logic [31:0] v);
    int a;
    for (int i = 0; i < elem_bytes(w); i++) begin
      a = e * elem_bytes(w) + i;
      model[(base + a / vec_cfg_pkg::VLENB) % vec_cfg_pkg::NUM_REGS][a % vec_cfg_pkg::VLENB]
        = v[8*i +: 8];  // upper bytes dropped, so results wrap
    end
  endtask

  task automatic apply_instr();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    for (int e = 0; e < vl; e++) begin
      a = get_elem(vs1, e, sew);
      b = get_elem(vs2, e, sew);
      case (op)
        vec_types_pkg::VADD:  r = b + a;
        vec_types_pkg::VSUB:  r = b - a;
        vec_types_pkg::VAND:  r = b & a;
        vec_types_pkg::VOR:   r = b | a;
        vec_types_pkg::VXOR:  r = b ^ a;
        vec_types_pkg::VMV_X: r = scalar;
        default:              r = a;  // copy of vs1
      endcase
      put_elem(vd, e, sew, r);
    end
  endtask

  // sampled mid-cycle, away from the driving edge
  always @(negedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int r = 0; r < vec_cfg_pkg::NUM_REGS; r++) begin
        for (int b = 0; b < vec_cfg_pkg::VLENB; b++) begin
          model[r][b] = 8'h00;
        end
      end
      cycle   = 0;
      pending = 1'b0;
    end else begin
      cycle++;
      if (!busy && rd_data !== get_elem(rd_reg, rd_offset, rd_sew)) begin
        note_mismatch($sformatf("host read v%0d[%0d]", rd_reg, rd_offset),
                      get_elem(rd_reg, rd_offset, rd_sew), rd_data);
      end
      if (pending) begin
        lat = cycle - start_cycle;
        if (done) begin
          if (lat != due) note_mismatch("done latency", due, lat);
          pending = 1'b0;
        end else if (lat >= due) begin
          note_error("done did not arrive at the expected cycle");
          pending = 1'b0;
        end else if (!busy) begin
          note_error("busy dropped before done");
        end
      end else if (busy || done) begin
        note_error("busy or done high without an accepted start");
      end
      if (start && !busy) begin  // accepted start
        apply_instr();
        start_cycle = cycle;
        due         = (vl + 1) / 2 + 2;
        pending     = 1'b1;
      end
    end
  end

endmodule

/* vec_unit.sv */
// vector unit top: sequencer, register file and lane ALU
`timescale 1ns/1ps

module vec_unit (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   start,
  input  vec_types_pkg::vop_t    op,
  input  vec_types_pkg::regsel_t vd,
  input  vec_types_pkg::regsel_t vs1,
  input  vec_types_pkg::regsel_t vs2,
  input  vec_types_pkg::sew_t    sew,
  input  vec_types_pkg::vlen_t   vl,
  input  vec_types_pkg::elem_t   scalar,
  input  vec_types_pkg::regsel_t rd_reg,
  input  vec_types_pkg::offset_t rd_offset,
  input  vec_types_pkg::sew_t    rd_sew,
  output vec_types_pkg::elem_t   rd_data,
  output logic                   busy,
  output logic                   done
);

  // sequencer to datapath
  logic                   issue;
  vec_types_pkg::vop_t    cur_op;
  vec_types_pkg::regsel_t cur_vd, cur_vs1, cur_vs2;
  vec_types_pkg::sew_t    cur_sew;
  vec_types_pkg::vlen_t   cur_vl;
  vec_types_pkg::elem_t   cur_scalar;
  vec_types_pkg::offset_t offset;

  // source operands
  vec_types_pkg::elem_t [vec_cfg_pkg::LANES-1:0] rs1_data, rs2_data;

  // write port
  logic                   wen;
  vec_types_pkg::regsel_t w_reg;
  vec_types_pkg::offset_t w_offset;
  vec_types_pkg::sew_t    w_sew;
  vec_types_pkg::vlen_t   w_vl;
  vec_types_pkg::elem_t [vec_cfg_pkg::LANES-1:0] w_data;

  vec_sequencer u_seq (
    .CLK, .nRST, .start, .op, .vd, .vs1, .vs2, .sew, .vl, .scalar,
    .busy, .done, .issue, .cur_op, .cur_vd, .cur_vs1, .cur_vs2,
    .cur_sew, .cur_vl, .cur_scalar, .offset
  );

  vec_reg_file u_rf (
    .CLK, .nRST, .sew(cur_sew), .vs1(cur_vs1), .vs2(cur_vs2), .rs_offset(offset),
    .wen, .w_reg, .w_offset, .w_sew, .w_vl, .w_data,
    .rd_reg, .rd_offset, .rd_sew, .rs1_data, .rs2_data, .rd_data
  );

  vec_lane_alu u_alu (
    .CLK, .nRST, .issue, .op(cur_op), .sew(cur_sew), .vd(cur_vd), .vl(cur_vl),
    .offset, .scalar(cur_scalar), .rs1_data, .rs2_data,
    .wen, .w_reg, .w_offset, .w_sew, .w_vl, .w_data
  );

endmodule

/* vec_lane_alu.sv */
// two-lane vector ALU with registered write-back stage
`timescale 1ns/1ps

module vec_lane_alu (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   issue,
  input  vec_types_pkg::vop_t    op,
  input  vec_types_pkg::sew_t    sew,
  input  vec_types_pkg::regsel_t vd,
  input  vec_types_pkg::vlen_t   vl,
  input  vec_types_pkg::offset_t offset,
  input  vec_types_pkg::elem_t   scalar,
  input  vec_types_pkg::elem_t   [vec_cfg_pkg::LANES-1:0] rs1_data,
  input  vec_types_pkg::elem_t   [vec_cfg_pkg::LANES-1:0] rs2_data,
  output logic                   wen,
  output vec_types_pkg::regsel_t w_reg,
  output vec_types_pkg::offset_t w_offset,
  output vec_types_pkg::sew_t    w_sew,
  output vec_types_pkg::vlen_t   w_vl,
  output vec_types_pkg::elem_t   [vec_cfg_pkg::LANES-1:0] w_data
);

  vec_types_pkg::elem_t [vec_cfg_pkg::LANES-1:0] result;

  // cut to element width, so add and sub wrap
  function automatic vec_types_pkg::elem_t trunc_elem(vec_types_pkg::elem_t v,
                                                      vec_types_pkg::sew_t s);
    case (s)
      vec_types_pkg::SEW32: return v;
      vec_types_pkg::SEW16: return {16'h0, v[15:0]};
      default:              return {24'h0, v[7:0]};
    endcase
  endfunction

  always_comb begin
    vec_types_pkg::elem_t raw;
    for (int l = 0; l < vec_cfg_pkg::LANES; l++) begin
      case (op)
        vec_types_pkg::VADD:  raw = rs2_data[l] + rs1_data[l];
        vec_types_pkg::VSUB:  raw = rs2_data[l] - rs1_data[l];
        vec_types_pkg::VAND:  raw = rs2_data[l] & rs1_data[l];
        vec_types_pkg::VOR:   raw = rs2_data[l] | rs1_data[l];
        vec_types_pkg::VXOR:  raw = rs2_data[l] ^ rs1_data[l];
        vec_types_pkg::VMV_X: raw = scalar;
        vec_types_pkg::VMV_V: raw = rs1_data[l];
        default:              raw = '0;
      endcase
      result[l] = trunc_elem(raw, sew);
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) wen <= 1'b0;
    else       wen <= issue;  // fixed one-cycle latency
  end

  // write-back payload, captured with each issued pair
  always_ff @(posedge CLK) begin
    if (issue) begin
      w_data   <= result;
      w_reg    <= vd;
      w_offset <= offset;
      w_sew    <= sew;
      w_vl     <= vl;
    end
  end

endmodule

/* vec_reg_file.sv */
// vector register file with two lane-pair read ports, host read port and masked write port
`timescale 1ns/1ps

module vec_reg_file (
  input  logic                   CLK,
  input  logic                   nRST,
  input  vec_types_pkg::sew_t    sew,
  input  vec_types_pkg::regsel_t vs1,
  input  vec_types_pkg::regsel_t vs2,
  input  vec_types_pkg::offset_t rs_offset,
  input  logic                   wen,
  input  vec_types_pkg::regsel_t w_reg,
  input  vec_types_pkg::offset_t w_offset,
  input  vec_types_pkg::sew_t    w_sew,
  input  vec_types_pkg::vlen_t   w_vl,
  input  vec_types_pkg::elem_t   [vec_cfg_pkg::LANES-1:0] w_data,
  input  vec_types_pkg::regsel_t rd_reg,
  input  vec_types_pkg::offset_t rd_offset,
  input  vec_types_pkg::sew_t    rd_sew,
  output vec_types_pkg::elem_t   [vec_cfg_pkg::LANES-1:0] rs1_data,
  output vec_types_pkg::elem_t   [vec_cfg_pkg::LANES-1:0] rs2_data,
  output vec_types_pkg::elem_t   rd_data
);

  vec_types_pkg::vreg_t registers      [vec_cfg_pkg::NUM_REGS];
  vec_types_pkg::vreg_t next_registers [vec_cfg_pkg::NUM_REGS];

  // register of the group holding this element, wraps mod 32
  function automatic vec_types_pkg::regsel_t elem_reg(vec_types_pkg::regsel_t base,
                                                      vec_types_pkg::offset_t off,
                                                      vec_types_pkg::sew_t s);
    logic [2:0] step;
    case (s)
      vec_types_pkg::SEW32: step = off[4:2];
      vec_types_pkg::SEW16: step = off[5:3];
      default:              step = off[6:4];
    endcase
    return base + vec_types_pkg::regsel_t'(step);
  endfunction

  // first byte of the element inside its register
  function automatic logic [3:0] elem_byte(vec_types_pkg::offset_t off,
                                           vec_types_pkg::sew_t s);
    logic [3:0] b;
    case (s)
      vec_types_pkg::SEW32: b = {off[1:0], 2'b00};
      vec_types_pkg::SEW16: b = {off[2:0], 1'b0};
      default:              b = off[3:0];
    endcase
    return b;
  endfunction

  function automatic vec_types_pkg::elem_t read_elem(vec_types_pkg::regsel_t base,
                                                     vec_types_pkg::offset_t off,
                                                     vec_types_pkg::sew_t s);
    vec_types_pkg::regsel_t r;
    logic [3:0] b;
    vec_types_pkg::elem_t v;
    r = elem_reg(base, off, s);
    b = elem_byte(off, s);
    case (s)
      vec_types_pkg::SEW32: v = registers[r][b +: 4];
      vec_types_pkg::SEW16: v = {16'h0, registers[r][b +: 2]};
      vec_types_pkg::SEW8:  v = {24'h0, registers[r][b]};
      default:              v = '0;
    endcase
    return v;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < vec_cfg_pkg::NUM_REGS; i++) begin
        registers[i] <= '0;
      end
    end else begin
      registers <= next_registers;
    end
  end

  // lane-pair write, each lane masked by vl on its own
  always_comb begin
    vec_types_pkg::offset_t off;
    vec_types_pkg::regsel_t r;
    logic [3:0] b;
    next_registers = registers;
    for (int l = 0; l < vec_cfg_pkg::LANES; l++) begin
      off = w_offset + vec_types_pkg::offset_t'(l);
      r   = elem_reg(w_reg, off, w_sew);
      b   = elem_byte(off, w_sew);
      if (wen && ({1'b0, off} < w_vl)) begin
        case (w_sew)
          vec_types_pkg::SEW32: next_registers[r][b +: 4] = w_data[l];
          vec_types_pkg::SEW16: next_registers[r][b +: 2] = w_data[l][15:0];
          vec_types_pkg::SEW8:  next_registers[r][b]      = w_data[l][7:0];
          default: ;  // unknown width writes nothing
        endcase
      end
    end
  end

  // source pairs share one offset, lane 1 is the next element
  always_comb begin
    for (int l = 0; l < vec_cfg_pkg::LANES; l++) begin
      rs1_data[l] = read_elem(vs1, rs_offset + vec_types_pkg::offset_t'(l), sew);
      rs2_data[l] = read_elem(vs2, rs_offset + vec_types_pkg::offset_t'(l), sew);
    end
    rd_data = read_elem(rd_reg, rd_offset, rd_sew);  // host port
  end

endmodule

/* vec_sequencer.sv */
// vector sequencer: instruction latch, element offset stepping, busy and done
`timescale 1ns/1ps

module vec_sequencer (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   start,
  input  vec_types_pkg::vop_t    op,
  input  vec_types_pkg::regsel_t vd,
  input  vec_types_pkg::regsel_t vs1,
  input  vec_types_pkg::regsel_t vs2,
  input  vec_types_pkg::sew_t    sew,
  input  vec_types_pkg::vlen_t   vl,
  input  vec_types_pkg::elem_t   scalar,
  output logic                   busy,
  output logic                   done,
  output logic                   issue,
  output vec_types_pkg::vop_t    cur_op,
  output vec_types_pkg::regsel_t cur_vd,
  output vec_types_pkg::regsel_t cur_vs1,
  output vec_types_pkg::regsel_t cur_vs2,
  output vec_types_pkg::sew_t    cur_sew,
  output vec_types_pkg::vlen_t   cur_vl,
  output vec_types_pkg::elem_t   cur_scalar,
  output vec_types_pkg::offset_t offset
);

  typedef enum logic [1:0] {IDLE, RUN, DRAIN} state_t;

  state_t state;
  logic   accept;
  logic   last_pair;

  assign accept = start && (state == IDLE);  // starts while busy are dropped

  // next pair would reach or pass vl
  assign last_pair = ({1'b0, offset} + vec_types_pkg::vlen_t'(vec_cfg_pkg::LANES)) >= cur_vl;

  assign busy  = (state != IDLE);
  assign issue = (state == RUN);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state  <= IDLE;
      offset <= '0;
      done   <= 1'b0;
    end else begin
      done <= (state == DRAIN);  // one cycle after the last write-back
      case (state)
        IDLE: begin
          offset <= '0;
          if (accept) begin
            state <= (vl == '0) ? DRAIN : RUN;  // vl of 0 skips the issue phase
          end
        end
        RUN: begin
          offset <= offset + vec_types_pkg::offset_t'(vec_cfg_pkg::LANES);
          if (last_pair) state <= DRAIN;
        end
        DRAIN: state <= IDLE;  // final write-back cycle
        default: state <= IDLE;
      endcase
    end
  end

  // instruction fields, held for the whole run
  always_ff @(posedge CLK) begin
    if (accept) begin
      cur_op     <= op;
      cur_vd     <= vd;
      cur_vs1    <= vs1;
      cur_vs2    <= vs2;
      cur_sew    <= sew;
      cur_vl     <= vl;
      cur_scalar <= scalar;
    end
  end

endmodule

/* vec_types_pkg.sv */
// element width and opcode enums, register and element data types
package vec_types_pkg;

  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2
  } sew_t;

  typedef enum logic [2:0] {
    VADD  = 3'd0,  // vs2 + vs1
    VSUB  = 3'd1,  // vs2 - vs1
    VAND  = 3'd2,
    VOR   = 3'd3,
    VXOR  = 3'd4,
    VMV_X = 3'd5,  // splat scalar
    VMV_V = 3'd6   // copy vs1
  } vop_t;

  // one vector register, byte addressed
  typedef logic [vec_cfg_pkg::VLENB-1:0][7:0] vreg_t;

  typedef logic [vec_cfg_pkg::OFFSET_W-1:0] offset_t;
  typedef logic [vec_cfg_pkg::VL_W-1:0]     vlen_t;
  typedef logic [vec_cfg_pkg::REG_W-1:0]    regsel_t;

  // lane word, narrow elements zero-extended in the low bits
  typedef logic [vec_cfg_pkg::ELEM_W-1:0] elem_t;

endpackage

/* vec_cfg_pkg.sv */
// register file geometry and derived widths for the vector slice
package vec_cfg_pkg;

  // register file shape
  localparam int NUM_REGS  = 32;
  localparam int VLENB     = 16;  // bytes per vector register
  localparam int LANES     = 2;   // elements per cycle
  localparam int MAX_GROUP = 8;   // registers one instruction may span

  // element counts
  localparam int MAX_VL = MAX_GROUP * VLENB;  // 128 at SEW 8

  // derived widths
  localparam int REG_W    = $clog2(NUM_REGS);
  localparam int OFFSET_W = $clog2(MAX_VL);
  localparam int VL_W     = $clog2(MAX_VL + 1);  // must hold vl == MAX_VL
  localparam int ELEM_W   = 32;

endpackage
